// ==== flist.f ====
rtl/chroni_pkg.sv
rtl/vga_timing.sv
rtl/text_fetch.sv
rtl/line_buffer.sv
rtl/vram.sv
rtl/chroni_regs.sv
rtl/chroni.sv
dv/chroni_tb.sv

// ==== Makefile ====
TOP = chroni_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/chroni_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni_tb
   import chroni_pkg::*;
();

   // six 800x600 frames, the 640x480 frames of the first tests and the loading
   localparam int WATCHDOG_NS = (6 * 1056 * 628 + 5 * 800 * 525 + 250_000) * 8;
   localparam logic [15:0] FG     = {FG_R, FG_G, FG_B};
   localparam logic [15:0] BG     = {BG_R, BG_G, BG_B};
   localparam logic [15:0] BORDER = {BORDER_R, BORDER_G, BORDER_B};

   logic        vga_clk;
   logic        reset_n;
   logic [1:0]  vga_mode_in;
   logic        vga_hs, vga_vs;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;
   logic [6:0]  cpu_addr;
   logic [7:0]  cpu_data_in;
   logic [7:0]  cpu_data_out;
   logic        cpu_we, cpu_re;
   logic [15:0] rgb;

   logic [7:0]  shadow [2**VRAM_ADDR_W];
   logic [12:0] ptr_model;
   int          cyc;
   int          errors;
   int          checks;

   chroni dut (
      .vga_clk(vga_clk), .reset_n(reset_n), .vga_mode_in(vga_mode_in),
      .vga_hs(vga_hs), .vga_vs(vga_vs),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .cpu_data_out(cpu_data_out),
      .cpu_we(cpu_we), .cpu_re(cpu_re)
   );

   assign rgb = {vga_r, vga_g, vga_b};

   always #4 vga_clk = !vga_clk;

   always @(posedge vga_clk) cyc <= cyc + 1;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("Simulation FAILED");
      $finish;
   end

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_color(input int line, input int px, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: rgb line %0d pixel %0d got %h expected %h",
                  $time, line, px, got, exp);
      end
   endtask

   task automatic reg_write(input cpu_reg_t addr, input logic [7:0] data);
      @(posedge vga_clk);
      cpu_addr    <= addr;
      cpu_data_in <= data;
      cpu_we      <= 1'b1;
      @(posedge vga_clk);
      cpu_we      <= 1'b0;
   endtask

   // cpu_data_out is registered in the cycle after cpu_re
   task automatic reg_read(input cpu_reg_t addr, output logic [7:0] data);
      @(posedge vga_clk);
      cpu_addr <= addr;
      cpu_re   <= 1'b1;
      @(posedge vga_clk);
      cpu_re   <= 1'b0;
      @(negedge vga_clk);
      data = cpu_data_out;
   endtask

   task automatic wait_idle();
      logic [7:0] st;
      int         polls;
      polls = 0;
      do begin
         reg_read(REG_STATUS, st);
         polls++;
      end while (st[0] && polls < 1000);
      if (st[0]) begin
         errors++;
         $display("busy never cleared after a VRAM access at %0t", $time);
      end
   endtask

   task automatic set_pointer(input logic [12:0] a);
      reg_write(REG_ADDR_LO, a[7:0]);
      reg_write(REG_ADDR_HI, {3'b000, a[12:8]});
      ptr_model = a;
   endtask

   task automatic data_write(input logic [7:0] d);
      reg_write(REG_DATA, d);
      wait_idle();
      shadow[ptr_model] = d;
      ptr_model = ptr_model + 13'd1;
   endtask

   task automatic data_read(output logic [7:0] d);
      reg_write(REG_STATUS, 8'h00);
      wait_idle();
      reg_read(REG_DATA, d);
      ptr_model = ptr_model + 13'd1;
   endtask

   task automatic pointer_check();
      logic [7:0] lo, hi;
      reg_read(REG_ADDR_LO, lo);
      reg_read(REG_ADDR_HI, hi);
      check_byte("pointer lo", lo, ptr_model[7:0]);
      check_byte("pointer hi", hi, {3'b000, ptr_model[12:8]});
   endtask

   task automatic text_readback();
      logic [7:0] d;
      set_pointer(13'(TEXT_BASE));
      for (int i = 0; i < TEXT_COLS * TEXT_ROWS; i++) begin
         data_read(d);
         check_byte("cpu_data_out", d, shadow[TEXT_BASE + i]);
      end
   endtask

   task automatic wait_hs(input logic level);
      do @(negedge vga_clk); while (vga_hs !== level);
   endtask

   task automatic wait_vs(input logic level);
      do @(negedge vga_clk); while (vga_vs !== level);
   endtask

   task automatic wait_lit();
      while (rgb == 16'h0000) @(negedge vga_clk);
   endtask

   task automatic wait_dark();
      while (rgb != 16'h0000) @(negedge vga_clk);
   endtask

   function automatic logic [15:0] expected_pixel(input int line, input int px);
      int         ly, lx;
      logic [7:0] code, glyph;
      ly    = line / 2;
      lx    = px / 2;
      code  = shadow[TEXT_BASE + (ly / 8) * TEXT_COLS + lx / 8];
      glyph = shadow[FONT_BASE + int'(code) * 8 + ly % 8];
      return glyph[7 - lx % 8] ? FG : BG;
   endfunction

   // one full frame, border lines on top and border pixels at both sides
   task automatic frame_compare(input logic vs_on, input int top_lines, input int side_px);
      int          base, width, pl;
      logic [15:0] exp;
      base  = errors;
      width = 640 + 2 * side_px;
      wait_vs(!vs_on);
      wait_vs(vs_on);
      for (int ln = 0; ln < top_lines + 480; ln++) begin
         wait_lit();
         pl = ln - top_lines;
         for (int px = 0; px < width; px++) begin
            if (ln < top_lines || px < side_px || px >= side_px + 640) exp = BORDER;
            else exp = expected_pixel(pl, px - side_px);
            check_color(ln, px, rgb, exp);
            if (errors != base) begin
               $display("frame compare stopped at line %0d", ln);
               return;
            end
            @(negedge vga_clk);
         end
         wait_dark();
      end
   endtask

   task automatic register_port_test();
      logic [12:0] start;
      logic [7:0]  d;
      start = 13'h1800 + 13'($urandom_range(0, 255));
      set_pointer(start);
      for (int i = 0; i < 16; i++) data_write(8'($urandom));
      pointer_check();
      set_pointer(start);
      for (int i = 0; i < 16; i++) begin
         data_read(d);
         check_byte("cpu_data_out", d, shadow[start + 13'(i)]);
      end
      pointer_check();
   endtask

   task automatic timing_640_test();
      int t0, t1, t2, lit;
      wait_hs(1'b1);
      wait_hs(1'b0);
      t0 = cyc;
      wait_hs(1'b1);
      t1 = cyc;
      wait_hs(1'b0);
      t2 = cyc;
      check_count("hsync low time", t1 - t0, 96);
      check_count("hsync period", t2 - t0, 800);
      wait_vs(1'b1);
      wait_vs(1'b0);
      t0 = cyc;
      wait_vs(1'b1);
      t1 = cyc;
      wait_vs(1'b0);
      t2 = cyc;
      check_count("vsync pulse clocks", t1 - t0, 2 * 800);
      check_count("vsync period clocks", t2 - t0, 525 * 800);
      for (int ln = 0; ln < 3; ln++) begin
         wait_lit();
         lit = 0;
         while (rgb != 16'h0000) begin
            lit++;
            @(negedge vga_clk);
         end
         check_count("lit pixels per line", lit, 640);
      end
   endtask

   task automatic text_render_test();
      set_pointer(13'(FONT_BASE));
      for (int i = 0; i < 32 * 8; i++) data_write(8'($urandom));
      set_pointer(13'(TEXT_BASE));
      for (int i = 0; i < TEXT_COLS * TEXT_ROWS; i++) data_write(8'($urandom_range(0, 31)));
      frame_compare(1'b0, 0, 0);
   endtask

   task automatic mode_switch_test();
      int t0, t1, t2;
      wait_vs(1'b1);
      wait_vs(1'b0);
      repeat (80_000) @(posedge vga_clk);
      vga_mode_in <= MODE_800X600;
      // the running frame keeps 640x480 timing
      wait_hs(1'b1);
      wait_hs(1'b0);
      t0 = cyc;
      wait_hs(1'b1);
      t1 = cyc;
      wait_hs(1'b0);
      t2 = cyc;
      check_count("hsync low time before switch", t1 - t0, 96);
      check_count("hsync period before switch", t2 - t0, 800);
      // frame end, then the first positive vsync pulse
      wait_vs(1'b0);
      wait_vs(1'b1);
      wait_vs(1'b0);
      wait_hs(1'b0);
      wait_hs(1'b1);
      t0 = cyc;
      wait_hs(1'b0);
      t1 = cyc;
      wait_hs(1'b1);
      t2 = cyc;
      check_count("hsync high time", t1 - t0, 128);
      check_count("hsync period", t2 - t0, 1056);
      frame_compare(1'b1, 60, 80);
   endtask

   task automatic load_access_test();
      set_pointer(13'(TEXT_BASE));
      for (int i = 0; i < TEXT_COLS * TEXT_ROWS; i++) data_write(8'($urandom_range(0, 31)));
      text_readback();
      frame_compare(1'b1, 60, 80);
   endtask

   initial begin
      void'($urandom(32'h245b));
      vga_clk     = 1'b0;
      reset_n     = 1'b0;
      vga_mode_in = MODE_640X480;
      cpu_addr    = 7'd0;
      cpu_data_in = 8'h00;
      cpu_we      = 1'b0;
      cpu_re      = 1'b0;
      cyc         = 0;
      errors      = 0;
      checks      = 0;
      ptr_model   = '0;
      repeat (3) @(posedge vga_clk);
      reset_n <= 1'b1;

      register_port_test();
      timing_640_test();
      text_render_test();
      mode_switch_test();
      load_access_test();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/chroni.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic [1:0] vga_mode_in,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic [4:0] vga_r,
   output logic [5:0] vga_g,
   output logic [4:0] vga_b,
   input  logic [6:0] cpu_addr,
   input  logic [7:0] cpu_data_in,
   output logic [7:0] cpu_data_out,
   input  logic       cpu_we,
   input  logic       cpu_re
);

   logic                   de, pf, line_start, pix_en, disp_half;
   logic                   fetch_start;
   logic [7:0]             fetch_row;
   logic                   fetch_req, fetch_ack;
   logic [VRAM_ADDR_W-1:0] fetch_addr;
   logic [7:0]             rdata;
   logic                   wr_en, wr_half;
   logic [5:0]             wr_col;
   logic [7:0]             wr_bits;
   logic                   cpu_req, cpu_wr, cpu_ack;
   logic [VRAM_ADDR_W-1:0] cpu_addr_v;
   logic [7:0]             cpu_wdata;

   vga_timing u_timing (
      .vga_clk(vga_clk), .reset_n(reset_n), .vga_mode_in(vga_mode_in),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .de(de), .pf(pf),
      .line_start(line_start), .pix_en(pix_en), .disp_half(disp_half),
      .fetch_start(fetch_start), .fetch_row(fetch_row)
   );

   text_fetch u_fetch (
      .vga_clk(vga_clk), .reset_n(reset_n),
      .fetch_start(fetch_start), .fetch_row(fetch_row),
      .fetch_req(fetch_req), .fetch_addr(fetch_addr),
      .fetch_ack(fetch_ack), .rdata(rdata),
      .wr_en(wr_en), .wr_half(wr_half), .wr_col(wr_col), .wr_bits(wr_bits)
   );

   line_buffer u_line (
      .vga_clk(vga_clk), .reset_n(reset_n),
      .wr_en(wr_en), .wr_half(wr_half), .wr_col(wr_col), .wr_bits(wr_bits),
      .line_start(line_start), .pix_en(pix_en), .disp_half(disp_half),
      .de(de), .pf(pf), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
   );

   vram u_vram (
      .vga_clk(vga_clk),
      .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_ack(fetch_ack),
      .cpu_req(cpu_req), .cpu_wr(cpu_wr), .cpu_addr_v(cpu_addr_v),
      .cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .rdata(rdata)
   );

   chroni_regs u_regs (
      .vga_clk(vga_clk), .reset_n(reset_n),
      .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in),
      .cpu_we(cpu_we), .cpu_re(cpu_re), .cpu_data_out(cpu_data_out),
      .cpu_req(cpu_req), .cpu_wr(cpu_wr), .cpu_addr_v(cpu_addr_v),
      .cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .rdata(rdata)
   );

endmodule

`default_nettype wire

// ==== rtl/chroni_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni_regs
   import chroni_pkg::*;
(
   input  logic                   vga_clk,
   input  logic                   reset_n,
   input  logic [6:0]             cpu_addr,
   input  logic [7:0]             cpu_data_in,
   input  logic                   cpu_we,
   input  logic                   cpu_re,
   output logic [7:0]             cpu_data_out,
   output logic                   cpu_req,
   output logic                   cpu_wr,
   output logic [VRAM_ADDR_W-1:0] cpu_addr_v,
   output logic [7:0]             cpu_wdata,
   input  logic                   cpu_ack,
   input  logic [7:0]             rdata
);

   logic [VRAM_ADDR_W-1:0] ptr;
   logic [7:0]             rd_latch;
   logic                   busy;
   logic                   start_wr;
   logic                   start_rd;

   assign start_wr = cpu_we && !busy && (cpu_addr == REG_DATA);
   assign start_rd = cpu_we && !busy && (cpu_addr == REG_STATUS);

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         ptr  <= '0;
         busy <= 1'b0;
      end else begin
         if (busy && cpu_ack) begin
            busy <= 1'b0;
            ptr  <= ptr + 1'b1;
         end
         if (start_wr || start_rd) busy <= 1'b1;
         if (cpu_we && cpu_addr == REG_ADDR_LO) ptr[7:0] <= cpu_data_in;
         if (cpu_we && cpu_addr == REG_ADDR_HI) ptr[VRAM_ADDR_W-1:8] <= cpu_data_in[4:0];
      end
   end

   // address and data are frozen for the whole access
   always_ff @(posedge vga_clk) begin
      if (start_wr || start_rd) begin
         cpu_addr_v <= ptr;
         cpu_wr     <= start_wr;
      end
      if (start_wr) cpu_wdata <= cpu_data_in;
      if (cpu_ack && !cpu_wr) rd_latch <= rdata;
   end

   assign cpu_req = busy;

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         cpu_data_out <= 8'h00;
      end else if (cpu_re) begin
         case (cpu_reg_t'(cpu_addr))
            REG_ADDR_LO: cpu_data_out <= ptr[7:0];
            REG_ADDR_HI: cpu_data_out <= {3'b000, ptr[VRAM_ADDR_W-1:8]};
            REG_DATA:    cpu_data_out <= rd_latch;
            REG_STATUS:  cpu_data_out <= {7'b0000000, busy};
            default:     cpu_data_out <= 8'h00;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/vram.sv ====
`timescale 1ns/1ps
`default_nettype none

module vram
   import chroni_pkg::*;
(
   input  logic                   vga_clk,
   input  logic                   fetch_req,
   input  logic [VRAM_ADDR_W-1:0] fetch_addr,
   output logic                   fetch_ack,
   input  logic                   cpu_req,
   input  logic                   cpu_wr,
   input  logic [VRAM_ADDR_W-1:0] cpu_addr_v,
   input  logic [7:0]             cpu_wdata,
   output logic                   cpu_ack,
   output logic [7:0]             rdata
);

   logic [7:0] mem [2**VRAM_ADDR_W];
   logic       fetch_go;
   logic       cpu_go;

   // a request still high in its ack cycle is already served
   assign fetch_go = fetch_req && !fetch_ack;
   assign cpu_go   = cpu_req && !cpu_ack && !fetch_go;

   always_ff @(posedge vga_clk) begin
      if (fetch_go) begin
         rdata <= mem[fetch_addr];
      end else if (cpu_go) begin
         if (cpu_wr) begin
            mem[cpu_addr_v] <= cpu_wdata;
         end else begin
            rdata <= mem[cpu_addr_v];
         end
      end
   end

   always_ff @(posedge vga_clk) begin
      fetch_ack <= fetch_go;
      cpu_ack   <= cpu_go;
   end

   // each requester drops its request in the ack cycle
   req_drop: assert property (@(posedge vga_clk)
      (fetch_ack |=> !fetch_req) and (cpu_ack |=> !cpu_req))
      else $error("request still high after its acknowledge");

endmodule

`default_nettype wire

// ==== rtl/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic       wr_en,
   input  logic       wr_half,
   input  logic [5:0] wr_col,
   input  logic [7:0] wr_bits,
   input  logic       line_start,
   input  logic       pix_en,
   input  logic       disp_half,
   input  logic       de,
   input  logic       pf,
   output logic [4:0] vga_r,
   output logic [5:0] vga_g,
   output logic [4:0] vga_b
);

   logic [LINE_PIXELS-1:0] lines [2];
   logic [8:0]             col;
   logic                   dbl;
   logic [8:0]             rd_col;
   logic                   pix_bit;

   // leftmost pixel is the font msb
   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         for (int k = 0; k < 8; k++) begin
            lines[wr_half][{wr_col, 3'(k)}] <= wr_bits[7 - k];
         end
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         col <= '0;
         dbl <= 1'b0;
      end else if (line_start) begin
         col <= '0;
         dbl <= 1'b1;
      end else if (pix_en) begin
         dbl <= !dbl;
         if (dbl && col != 9'(LINE_PIXELS - 1)) col <= col + 9'd1;
      end
   end

   // column 0 shows already in the line_start cycle
   assign rd_col  = line_start ? 9'd0 : col;
   assign pix_bit = lines[disp_half][rd_col];

   always_comb begin
      if (!de) begin
         {vga_r, vga_g, vga_b} = '0;
      end else if (!pf) begin
         {vga_r, vga_g, vga_b} = {BORDER_R, BORDER_G, BORDER_B};
      end else if (pix_bit) begin
         {vga_r, vga_g, vga_b} = {FG_R, FG_G, FG_B};
      end else begin
         {vga_r, vga_g, vga_b} = {BG_R, BG_G, BG_B};
      end
   end

endmodule

`default_nettype wire

// ==== rtl/text_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_fetch
   import chroni_pkg::*;
(
   input  logic                   vga_clk,
   input  logic                   reset_n,
   input  logic                   fetch_start,
   input  logic [7:0]             fetch_row,
   output logic                   fetch_req,
   output logic [VRAM_ADDR_W-1:0] fetch_addr,
   input  logic                   fetch_ack,
   input  logic [7:0]             rdata,
   output logic                   wr_en,
   output logic                   wr_half,
   output logic [5:0]             wr_col,
   output logic [7:0]             wr_bits
);

   fetch_state_t           state;
   logic [7:0]             row_q;
   logic [5:0]             col;
   logic [7:0]             code;
   logic [7:0]             glyph;
   logic [VRAM_ADDR_W-1:0] text_addr;
   logic [VRAM_ADDR_W-1:0] font_addr;

   // text is row-major, one text row covers eight glyph rows
   assign text_addr = VRAM_ADDR_W'(TEXT_BASE)
                    + VRAM_ADDR_W'(row_q[7:3]) * VRAM_ADDR_W'(TEXT_COLS)
                    + VRAM_ADDR_W'(col);
   assign font_addr = VRAM_ADDR_W'(FONT_BASE) + VRAM_ADDR_W'({code, row_q[2:0]});

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state     <= FETCH_IDLE;
         fetch_req <= 1'b0;
         col       <= '0;
      end else begin
         case (state)
            FETCH_IDLE: begin
               if (fetch_start) begin
                  col   <= '0;
                  state <= FETCH_TEXT;
               end
            end
            FETCH_TEXT: begin
               fetch_req <= 1'b1;
               state     <= FETCH_TEXT_WAIT;
            end
            FETCH_TEXT_WAIT: begin
               if (fetch_ack) begin
                  fetch_req <= 1'b0;
                  state     <= FETCH_FONT;
               end
            end
            FETCH_FONT: begin
               fetch_req <= 1'b1;
               state     <= FETCH_FONT_WAIT;
            end
            FETCH_FONT_WAIT: begin
               if (fetch_ack) begin
                  fetch_req <= 1'b0;
                  state     <= FETCH_SHIFT;
               end
            end
            FETCH_SHIFT: begin
               if (col == 6'(TEXT_COLS - 1)) begin
                  state <= FETCH_IDLE;
               end else begin
                  col   <= col + 6'd1;
                  state <= FETCH_TEXT;
               end
            end
            default: state <= FETCH_IDLE;
         endcase
      end
   end

   always_ff @(posedge vga_clk) begin
      if (state == FETCH_IDLE && fetch_start) row_q <= fetch_row;
      if (state == FETCH_TEXT) fetch_addr <= text_addr;
      if (state == FETCH_FONT) fetch_addr <= font_addr;
      if (state == FETCH_TEXT_WAIT && fetch_ack) code <= rdata;
      if (state == FETCH_FONT_WAIT && fetch_ack) glyph <= rdata;
   end

   assign wr_en   = (state == FETCH_SHIFT);
   assign wr_half = row_q[0];
   assign wr_col  = col;
   assign wr_bits = glyph;

   start_idle: assert property (@(posedge vga_clk) disable iff (!reset_n)
      fetch_start |-> state == FETCH_IDLE)
      else $error("fetch_start while a line fetch is still running");

endmodule

`default_nettype wire

// ==== rtl/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing
   import chroni_pkg::*;
(
   input  logic       vga_clk,
   input  logic       reset_n,
   input  logic [1:0] vga_mode_in,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic       de,
   output logic       pf,
   output logic       line_start,
   output logic       pix_en,
   output logic       disp_half,
   output logic       fetch_start,
   output logic [7:0] fetch_row
);

   vga_mode_t   mode;
   logic [11:0] x_cnt, y_cnt;
   logic [11:0] h_total, h_sync, h_bp, h_active, pf_x;
   logic [11:0] v_total, v_sync, v_bp, v_active, pf_y_off;
   logic        sync_pos;
   logic [11:0] h_de_start, h_de_end, h_pf_start, h_pf_end;
   logic [11:0] v_de_start, v_de_end, v_pf_start, v_pf_end;
   logic        h_de_in, v_de_in, h_pf_in, v_pf_in;
   logic [11:0] pf_y;
   logic        pre_line, row_line;

   always_comb begin
      if (mode == MODE_800X600) begin
         h_total  = 12'(H_TOTAL_800);
         h_sync   = 12'(H_SYNC_800);
         h_bp     = 12'(H_BP_800);
         h_active = 12'(H_ACTIVE_800);
         pf_x     = 12'(PF_X_800);
         v_total  = 12'(V_TOTAL_800);
         v_sync   = 12'(V_SYNC_800);
         v_bp     = 12'(V_BP_800);
         v_active = 12'(V_ACTIVE_800);
         pf_y_off = 12'(PF_Y_800);
         sync_pos = SYNC_POS_800;
      end else begin
         h_total  = 12'(H_TOTAL_640);
         h_sync   = 12'(H_SYNC_640);
         h_bp     = 12'(H_BP_640);
         h_active = 12'(H_ACTIVE_640);
         pf_x     = 12'(PF_X_640);
         v_total  = 12'(V_TOTAL_640);
         v_sync   = 12'(V_SYNC_640);
         v_bp     = 12'(V_BP_640);
         v_active = 12'(V_ACTIVE_640);
         pf_y_off = 12'(PF_Y_640);
         sync_pos = SYNC_POS_640;
      end
   end

   assign h_de_start = h_sync + h_bp + 12'd1;
   assign h_de_end   = h_sync + h_bp + h_active;
   assign h_pf_start = h_de_start + pf_x;
   assign h_pf_end   = h_pf_start + 12'(PF_WIDTH) - 12'd1;
   assign v_de_start = v_sync + v_bp + 12'd1;
   assign v_de_end   = v_sync + v_bp + v_active;
   assign v_pf_start = v_de_start + pf_y_off;
   assign v_pf_end   = v_pf_start + 12'(PF_HEIGHT) - 12'd1;

   assign h_de_in = (x_cnt >= h_de_start) && (x_cnt <= h_de_end);
   assign v_de_in = (y_cnt >= v_de_start) && (y_cnt <= v_de_end);
   assign h_pf_in = (x_cnt >= h_pf_start) && (x_cnt <= h_pf_end);
   assign v_pf_in = (y_cnt >= v_pf_start) && (y_cnt <= v_pf_end);

   // physical line inside the playfield, two per logical line
   assign pf_y     = y_cnt - v_pf_start;
   assign pre_line = (y_cnt == v_pf_start - 12'd1);
   assign row_line = v_pf_in && !pf_y[0] && (pf_y[8:1] < 8'(TEXT_ROWS * 8 - 1));

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         mode  <= MODE_640X480;
         x_cnt <= 12'd1;
         y_cnt <= 12'd1;
      end else begin
         // unsupported codes keep the current mode
         if (x_cnt == 12'd1 && y_cnt == 12'd1 &&
             (vga_mode_in == MODE_640X480 || vga_mode_in == MODE_800X600)) begin
            mode <= vga_mode_t'(vga_mode_in);
         end
         if (x_cnt == h_total) begin
            x_cnt <= 12'd1;
            y_cnt <= (y_cnt == v_total) ? 12'd1 : y_cnt + 12'd1;
         end else begin
            x_cnt <= x_cnt + 12'd1;
         end
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         vga_hs      <= !SYNC_POS_640;
         vga_vs      <= !SYNC_POS_640;
         de          <= 1'b0;
         pf          <= 1'b0;
         line_start  <= 1'b0;
         fetch_start <= 1'b0;
      end else begin
         vga_hs      <= (x_cnt <= h_sync) ? sync_pos : !sync_pos;
         vga_vs      <= (y_cnt <= v_sync) ? sync_pos : !sync_pos;
         de          <= h_de_in && v_de_in;
         pf          <= h_pf_in && v_pf_in;
         line_start  <= (x_cnt == h_pf_start) && v_pf_in;
         fetch_start <= (x_cnt == 12'd1) && (pre_line || row_line);
      end
   end

   // row n+1 is fetched while row n is on screen
   always_ff @(posedge vga_clk) begin
      fetch_row <= pre_line ? 8'd0 : pf_y[8:1] + 8'd1;
      disp_half <= pf_y[1];
   end

   assign pix_en = pf;

   hs_edges: assert property (@(posedge vga_clk) disable iff (!reset_n)
      ($changed(vga_hs) && $past(mode, 2) == mode) |->
         ($past(x_cnt) == 12'd1 || $past(x_cnt) == h_sync + 12'd1))
      else $error("vga_hs toggled off a sync boundary");

endmodule

`default_nettype wire

// ==== rtl/chroni_pkg.sv ====
`default_nettype none

package chroni_pkg;

   typedef enum logic [1:0] {
      MODE_640X480 = 2'd0,
      MODE_800X600 = 2'd1
   } vga_mode_t;

   typedef enum logic [6:0] {
      REG_ADDR_LO = 7'd0,
      REG_ADDR_HI = 7'd1,
      REG_DATA    = 7'd2,
      REG_STATUS  = 7'd3
   } cpu_reg_t;

   typedef enum logic [2:0] {
      FETCH_IDLE,
      FETCH_TEXT,
      FETCH_TEXT_WAIT,
      FETCH_FONT,
      FETCH_FONT_WAIT,
      FETCH_SHIFT
   } fetch_state_t;

   // 640x480, negative sync
   localparam int   H_TOTAL_640  = 800;
   localparam int   H_SYNC_640   = 96;
   localparam int   H_BP_640     = 48;
   localparam int   H_ACTIVE_640 = 640;
   localparam int   V_TOTAL_640  = 525;
   localparam int   V_SYNC_640   = 2;
   localparam int   V_BP_640     = 33;
   localparam int   V_ACTIVE_640 = 480;
   localparam logic SYNC_POS_640 = 1'b0;
   localparam int   PF_X_640     = 0;
   localparam int   PF_Y_640     = 0;

   // 800x600, positive sync
   localparam int   H_TOTAL_800  = 1056;
   localparam int   H_SYNC_800   = 128;
   localparam int   H_BP_800     = 88;
   localparam int   H_ACTIVE_800 = 800;
   localparam int   V_TOTAL_800  = 628;
   localparam int   V_SYNC_800   = 4;
   localparam int   V_BP_800     = 23;
   localparam int   V_ACTIVE_800 = 600;
   localparam logic SYNC_POS_800 = 1'b1;
   localparam int   PF_X_800     = 80;
   localparam int   PF_Y_800     = 60;

   // playfield in physical pixels, every logical pixel doubled
   localparam int PF_WIDTH    = 640;
   localparam int PF_HEIGHT   = 480;

   localparam int VRAM_ADDR_W = 13;
   localparam int FONT_BASE   = 0;
   localparam int TEXT_BASE   = 1024;
   localparam int TEXT_COLS   = 40;
   localparam int TEXT_ROWS   = 30;
   localparam int LINE_PIXELS = 320;

   localparam logic [4:0] FG_R     = 5'd19;
   localparam logic [5:0] FG_G     = 6'd39;
   localparam logic [4:0] FG_B     = 5'd19;
   localparam logic [4:0] BG_R     = 5'd2;
   localparam logic [5:0] BG_G     = 6'd4;
   localparam logic [4:0] BG_B     = 5'd10;
   localparam logic [4:0] BORDER_R = 5'd4;
   localparam logic [5:0] BORDER_G = 6'd8;
   localparam logic [4:0] BORDER_B = 5'd6;

endpackage

`default_nettype wire
